//--- Makefile
# Verilator flow for the read-response checker

BUILD := obj_dir
LOG   := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module sc_response_checker

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module tb_sc_response_checker --Mdir $(BUILD) -o tb_sim
	./$(BUILD)/tb_sim | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- hdl/axi_rsp_pkg.sv
// Read-response bus types of the memory-test accelerator that the checker RTL and testbench share
`default_nettype none

package axi_rsp_pkg;

  // ====================
  // bus geometry
  // ====================
  localparam int ID_W   = 9;
  localparam int DATA_W = 512;

  // response code as carried on the read channel where only OKAY and SLVERR are produced
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_e;

  // one beat of the read-response channel whose valid is a strobe and not a handshake
  typedef struct packed {
    logic              valid;
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    resp_e             resp;
    logic              poison;
  } rd_rsp_t;

endpackage

`default_nettype wire

//--- hdl/byte_compare.sv
// Third datapath stage of the checker that registers the masked per-byte mismatches of each response
`default_nettype none
`timescale 1ns/1ps

module byte_compare (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                i_ready,
  input  logic [verify_pkg::LINE_BYTES-1:0]   i_mask,
  input  verify_pkg::stage_t                  i_stage,
  input  logic [verify_pkg::LINE_BYTES*8-1:0] i_expected_line,
  output verify_pkg::stage_t                  o_stage,
  output logic [verify_pkg::LINE_BYTES-1:0]   o_mismatch
);

  logic [verify_pkg::LINE_BYTES-1:0] lane_diff;

  // a lane only counts as failing when its mask bit is set
  always_comb
  begin
    for (int b = 0; b < verify_pkg::LINE_BYTES; b++)
      lane_diff[b] = i_mask[b] && (i_stage.data[8*b +: 8] != i_expected_line[8*b +: 8]);
  end

  always_ff @(posedge clk)
  begin
    if (i_stage.valid)
    begin
      o_stage    <= i_stage;
      o_mismatch <= lane_diff;
    end

    if (!reset_n)
      o_stage.valid <= 1'b0;
    else
      o_stage.valid <= i_ready && i_stage.valid;
  end

endmodule

`default_nettype wire

//--- hdl/error_record.sv
// Last datapath stage of the checker that keeps the first failing response and the error flags
`default_nettype none
`timescale 1ns/1ps

module error_record (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               i_clear,
  input  verify_pkg::pattern_size_e          i_size,
  input  verify_pkg::stage_t                 i_stage,
  input  logic [verify_pkg::LINE_BYTES-1:0]  i_mismatch,
  output logic                               o_error_found,
  output logic                               o_detail_ready,
  output logic                               o_slverr,
  output logic                               o_poison,
  output logic [7:0]                         o_error_id,
  output logic [verify_pkg::PATTERN_W-1:0]   o_expected_pattern,
  output logic [verify_pkg::PATTERN_W-1:0]   o_received_pattern,
  output logic [verify_pkg::OFFSET_W-1:0]    o_byte_offset
);

  logic                                first_fail;
  logic [axi_rsp_pkg::ID_W-1:0]        err_id;
  logic [verify_pkg::PATTERN_W-1:0]    err_pattern;
  logic [verify_pkg::LINE_BYTES*8-1:0] err_data;
  logic [verify_pkg::LINE_BYTES-1:0]   err_mask;
  logic [verify_pkg::OFFSET_W-1:0]     offset;
  logic [verify_pkg::PATTERN_W-1:0]    element;

  // only the first failing response of a run is kept
  assign first_fail = i_stage.valid && (|i_mismatch) && !o_error_found;

  // ====================
  // flags
  // ====================
  always_ff @(posedge clk)
  begin
    if (!reset_n || i_clear)
    begin
      o_error_found <= 1'b0;
      o_slverr      <= 1'b0;
      o_poison      <= 1'b0;
    end
    else
    begin
      if (first_fail)
        o_error_found <= 1'b1;
      if (i_stage.valid)
      begin
        o_slverr <= o_slverr | i_stage.slverr;
        o_poison <= o_poison | i_stage.poison;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (first_fail)
    begin
      err_id      <= i_stage.id;
      err_pattern <= i_stage.pattern;
      err_data    <= i_stage.data;
      err_mask    <= i_mismatch;
    end
  end

  // ====================
  // error details
  // ====================
  // scanning downwards leaves the lowest failing lane in offset
  always_comb
  begin
    offset = '0;
    for (int b = verify_pkg::LINE_BYTES - 1; b >= 0; b--)
    begin
      if (err_mask[b])
        offset = b[verify_pkg::OFFSET_W-1:0];
    end
  end

  // the element is aligned to the pattern size and zero-extended
  always_comb
  begin
    element = '0;
    case (i_size)
      verify_pkg::SIZE_8:
        element[7:0] = err_data[{offset, 3'b000} +: 8];
      verify_pkg::SIZE_16:
        element[15:0] = err_data[{offset[verify_pkg::OFFSET_W-1:1], 4'b0000} +: 16];
      default:
        element = err_data[{offset[verify_pkg::OFFSET_W-1:2], 5'b00000} +: 32];
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || i_clear)
      o_detail_ready <= 1'b0;
    else
      o_detail_ready <= o_error_found;
  end

  always_ff @(posedge clk)
  begin
    if (o_error_found && !o_detail_ready)
    begin
      o_byte_offset      <= offset;
      o_received_pattern <= element;
    end
  end

  assign o_error_id         = err_id[7:0];
  assign o_expected_pattern = err_pattern;

endmodule

`default_nettype wire

//--- hdl/pattern_expand.sv
// Second datapath stage of the checker that repeats the expected pattern across the line
`default_nettype none
`timescale 1ns/1ps

module pattern_expand (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 i_ready,
  input  verify_pkg::pattern_size_e            i_size,
  input  verify_pkg::stage_t                   i_stage,
  output verify_pkg::stage_t                   o_stage,
  output logic [verify_pkg::LINE_BYTES*8-1:0]  o_expected_line
);

  logic [verify_pkg::LINE_BYTES*8-1:0] line;

  // replication puts element 0 in the lowest bytes, so the line is little-endian
  always_comb
  begin
    case (i_size)
      verify_pkg::SIZE_8:
        line = {verify_pkg::LINE_BYTES{i_stage.pattern[7:0]}};
      verify_pkg::SIZE_16:
        line = {(verify_pkg::LINE_BYTES / 2){i_stage.pattern[15:0]}};
      default:
        line = {(verify_pkg::LINE_BYTES * 8 / verify_pkg::PATTERN_W){i_stage.pattern}};
    endcase
  end

  // ====================
  // stage register
  // ====================
  always_ff @(posedge clk)
  begin
    if (i_stage.valid)
    begin
      o_stage         <= i_stage;
      o_expected_line <= line;
    end

    // ready low flushes whatever is still in flight
    if (!reset_n)
      o_stage.valid <= 1'b0;
    else
      o_stage.valid <= i_ready && i_stage.valid;
  end

endmodule

`default_nettype wire

//--- hdl/rsp_capture_stage.sv
// First datapath stage of the checker that registers accepted responses and forms id plus base
`default_nettype none
`timescale 1ns/1ps

module rsp_capture_stage (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             i_ready,
  input  logic                             i_clear,
  input  logic [verify_pkg::PATTERN_W-1:0] i_base,
  input  axi_rsp_pkg::rd_rsp_t             i_rsp,
  output verify_pkg::stage_t               o_stage
);

  // response id widened to the pattern width
  logic [verify_pkg::PATTERN_W-1:0] id_ext;

  always_comb
  begin
    id_ext = '0;
    id_ext[axi_rsp_pkg::ID_W-1:0] = i_rsp.id;
  end

  // ====================
  // capture register
  // ====================
  always_ff @(posedge clk)
  begin
    // payload only moves with a valid beat and the valid bit below decides if it counts
    if (i_rsp.valid)
    begin
      o_stage.id      <= i_rsp.id;
      o_stage.pattern <= id_ext + i_base;
      o_stage.data    <= i_rsp.data;
      o_stage.slverr  <= (i_rsp.resp == axi_rsp_pkg::RESP_SLVERR);
      o_stage.poison  <= i_rsp.poison;
    end

    // a beat offered while ready is low is dropped here
    if (!reset_n)
      o_stage.valid <= 1'b0;
    else if (i_clear)
      o_stage.valid <= 1'b0;
    else
      o_stage.valid <= i_ready && i_rsp.valid;
  end

endmodule

`default_nettype wire

//--- hdl/sc_response_checker.sv
// Top level of the read-response checker that joins the run control to the four datapath stages
`default_nettype none
`timescale 1ns/1ps

module sc_response_checker (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              i_start,
  input  verify_pkg::run_cfg_t              i_cfg,
  input  axi_rsp_pkg::rd_rsp_t              i_rsp,
  output logic                              o_busy,
  output logic                              o_rready,
  output logic                              o_record_error,
  output logic                              o_error_found,
  output logic                              o_slverr,
  output logic                              o_poison,
  output logic [7:0]                        o_error_id,
  output logic [verify_pkg::PATTERN_W-1:0]  o_expected_pattern,
  output logic [verify_pkg::PATTERN_W-1:0]  o_received_pattern,
  output logic [verify_pkg::OFFSET_W-1:0]   o_byte_offset
);

  verify_pkg::run_cfg_t                run_cfg;
  logic                                clear;
  logic                                detail_ready;
  verify_pkg::stage_t                  cap_stage;
  verify_pkg::stage_t                  exp_stage;
  verify_pkg::stage_t                  cmp_stage;
  logic [verify_pkg::LINE_BYTES*8-1:0] expected_line;
  logic [verify_pkg::LINE_BYTES-1:0]   mismatch;

  verify_ctrl u_ctrl (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_start        (i_start),
    .i_cfg          (i_cfg),
    .i_rsp_valid    (cmp_stage.valid),
    .i_error_found  (o_error_found),
    .i_detail_ready (detail_ready),
    .o_cfg          (run_cfg),
    .o_clear        (clear),
    .o_rready       (o_rready),
    .o_busy         (o_busy),
    .o_record_error (o_record_error)
  );

  // ====================
  // datapath
  // ====================
  rsp_capture_stage u_capture (
    .clk     (clk),
    .reset_n (reset_n),
    .i_ready (o_rready),
    .i_clear (clear),
    .i_base  (run_cfg.base),
    .i_rsp   (i_rsp),
    .o_stage (cap_stage)
  );

  pattern_expand u_expand (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_ready         (o_rready),
    .i_size          (run_cfg.size),
    .i_stage         (cap_stage),
    .o_stage         (exp_stage),
    .o_expected_line (expected_line)
  );

  byte_compare u_compare (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_ready         (o_rready),
    .i_mask          (run_cfg.mask),
    .i_stage         (exp_stage),
    .i_expected_line (expected_line),
    .o_stage         (cmp_stage),
    .o_mismatch      (mismatch)
  );

  error_record u_record (
    .clk                (clk),
    .reset_n            (reset_n),
    .i_clear            (clear),
    .i_size             (run_cfg.size),
    .i_stage            (cmp_stage),
    .i_mismatch         (mismatch),
    .o_error_found      (o_error_found),
    .o_detail_ready     (detail_ready),
    .o_slverr           (o_slverr),
    .o_poison           (o_poison),
    .o_error_id         (o_error_id),
    .o_expected_pattern (o_expected_pattern),
    .o_received_pattern (o_received_pattern),
    .o_byte_offset      (o_byte_offset)
  );

endmodule

`default_nettype wire

//--- hdl/verify_ctrl.sv
// Run control of the checker that latches the configuration, counts responses and drives busy
`default_nettype none
`timescale 1ns/1ps

module verify_ctrl (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 i_start,
  input  verify_pkg::run_cfg_t i_cfg,
  input  logic                 i_rsp_valid,
  input  logic                 i_error_found,
  input  logic                 i_detail_ready,
  output verify_pkg::run_cfg_t o_cfg,
  output logic                 o_clear,
  output logic                 o_rready,
  output logic                 o_busy,
  output logic                 o_record_error
);

  typedef enum logic [2:0] {
    IDLE,
    RUN,
    GATHER,
    RECORD,
    FINISH
  } state_e;

  state_e                        state;
  state_e                        next_state;
  logic                          start_run;
  logic [verify_pkg::COUNT_W:0]  rsp_count;
  logic [verify_pkg::COUNT_W:0]  run_total;

  // a start pulse outside IDLE is ignored
  assign start_run = (state == IDLE) && i_start;
  assign o_clear   = start_run;
  assign run_total = {1'b0, o_cfg.count} + 1'b1;

  // ====================
  // state machine
  // ====================
  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
        if (i_start)
          next_state = RUN;
      RUN:
        // a mismatch wins over the count, so a failing last response is still reported
        if (i_error_found)
          next_state = GATHER;
        else if (rsp_count == run_total)
          next_state = FINISH;
      GATHER:
        if (i_detail_ready)
          next_state = RECORD;
      RECORD:
        next_state = FINISH;
      default:
        next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_ff @(posedge clk)
  begin
    if (start_run)
      o_cfg <= i_cfg;
  end

  // counts responses leaving the compare stage
  always_ff @(posedge clk)
  begin
    if (!reset_n || start_run)
      rsp_count <= '0;
    else if ((state == RUN) && i_rsp_valid)
      rsp_count <= rsp_count + 1'b1;
  end

  // ====================
  // output levels
  // ====================
  // busy and ready fall together when FINISH is left and record fires in the FINISH cycle
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      o_busy         <= 1'b0;
      o_rready       <= 1'b0;
      o_record_error <= 1'b0;
    end
    else
    begin
      o_record_error <= (state == RECORD);
      if (start_run)
      begin
        o_busy   <= 1'b1;
        o_rready <= 1'b1;
      end
      else if (state == FINISH)
      begin
        o_busy   <= 1'b0;
        o_rready <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/verify_pkg.sv
// Line geometry, pattern size and run configuration types that every checker module refers to
`default_nettype none

package verify_pkg;

  // ====================
  // line geometry
  // ====================
  localparam int LINE_BYTES = 64;
  localparam int PATTERN_W  = 32;
  localparam int COUNT_W    = 9;
  localparam int OFFSET_W   = $clog2(LINE_BYTES);

  // width of one pattern element in the line
  typedef enum logic [1:0] {
    SIZE_8  = 2'd0,
    SIZE_16 = 2'd1,
    SIZE_32 = 2'd2
  } pattern_size_e;

  // ====================
  // run configuration
  // ====================
  // count holds the number of expected responses minus one
  typedef struct packed {
    logic [COUNT_W-1:0]    count;
    logic [PATTERN_W-1:0]  base;
    pattern_size_e         size;
    logic [LINE_BYTES-1:0] mask;
  } run_cfg_t;

  // one response as it moves between the datapath stages
  typedef struct packed {
    logic                        valid;
    logic [axi_rsp_pkg::ID_W-1:0] id;
    logic [PATTERN_W-1:0]        pattern;
    logic [LINE_BYTES*8-1:0]     data;
    logic                        slverr;
    logic                        poison;
  } stage_t;

endpackage

`default_nettype wire

//--- test/tb_sc_response_checker.sv
// Self-checking testbench of the read-response checker that plays runs against a reference model
`default_nettype none
`timescale 1ns/1ps

module tb_sc_response_checker;

  logic                     clk = 1'b0;
  logic                     reset_n;
  logic                     i_start;
  verify_pkg::run_cfg_t     i_cfg;
  axi_rsp_pkg::rd_rsp_t     i_rsp;
  logic                     o_busy;
  logic                     o_rready;
  logic                     o_record_error;
  logic                     o_error_found;
  logic                     o_slverr;
  logic                     o_poison;
  logic [7:0]               o_error_id;
  logic [31:0]              o_expected_pattern;
  logic [31:0]              o_received_pattern;
  logic [5:0]               o_byte_offset;

  integer      seed;
  logic [63:0] part_mask;
  int          prop_errors = 0;
  int          value_errors = 0;
  int          event_errors = 0;
  int          record_pulses = 0;
  int          sent_total = 0;
  int          cycle_count = 0;
  bit          timed_out = 1'b0;

  always #10 clk = ~clk;

  sc_response_checker i_dut (.*);

  // ====================
  // protocol checks
  // ====================
  assert property (@(posedge clk) disable iff (!reset_n) !o_busy |-> !o_rready)
  else
  begin
    prop_errors++;
    $display("** Error at %0t: o_rready high while o_busy is low", $time);
  end

  assert property (@(posedge clk) disable iff (!reset_n) o_record_error |-> o_busy && o_error_found)
  else
  begin
    prop_errors++;
    $display("** Error at %0t: o_record_error outside a failing busy run", $time);
  end

  // the record pulse sits in the last busy cycle of a failing run
  assert property (@(posedge clk) disable iff (!reset_n)
                   $fell(o_busy) |-> $past(o_record_error) == o_error_found)
  else
  begin
    prop_errors++;
    $display("** Error at %0t: o_record_error not in the cycle before busy fell", $time);
  end

  always @(posedge clk)
  begin
    if (o_record_error)
      record_pulses <= record_pulses + 1;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > 200 + 40 * sent_total)
    begin
      $display("timeout: the test did not finish within %0d cycles", cycle_count);
      timed_out = 1'b1;
      end_simulation();
    end
  end

  // ====================
  // reference model
  // ====================
  function automatic int element_bytes(input verify_pkg::pattern_size_e size);
    case (size)
      verify_pkg::SIZE_8:  return 1;
      verify_pkg::SIZE_16: return 2;
      default:             return 4;
    endcase
  endfunction

  // byte b of the line holds pattern byte b modulo the element size with the lowest byte first
  function automatic logic [511:0] repeat_pattern(input logic [31:0] pattern, input int nb);
    logic [511:0] line;
    for (int b = 0; b < 64; b++)
      line[8*b +: 8] = pattern[8*(b % nb) +: 8];
    return line;
  endfunction

  task automatic expect_equal(input string what, input logic [31:0] got, input logic [31:0] want);
    assert (got == want)
    else
    begin
      value_errors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  task automatic end_simulation;
    $display("errors: %0d property, %0d value, %0d event, %0d timeout",
             prop_errors, value_errors, event_errors, timed_out);
    if (prop_errors + value_errors + event_errors == 0 && !timed_out)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  endtask

  // one run of n responses where bad_a and bad_b pick corrupted responses and end sending early
  task automatic play_run(input verify_pkg::pattern_size_e size, input logic [63:0] mask,
                          input int n, input int bad_a, input int bad_b, input bit noise,
                          input int slverr_at, input int poison_at);
    verify_pkg::run_cfg_t cfg;
    axi_rsp_pkg::rd_rsp_t rsp;
    logic [511:0]         used;
    logic [511:0]         expect_line;
    logic [63:0]          mism;
    logic [31:0]          r;
    logic [31:0]          pattern;
    logic [31:0]          exp_pattern;
    logic [31:0]          exp_element;
    logic [8:0]           exp_id;
    int                   nb;
    int                   last;
    int                   pos;
    int                   exp_offset;
    int                   pulses_before;
    bit                   exp_found;
    bit                   exp_slverr;
    bit                   exp_poison;

    nb = element_bytes(size);
    used = '0;
    exp_found = 1'b0;
    exp_slverr = 1'b0;
    exp_poison = 1'b0;
    exp_id = '0;
    exp_pattern = '0;
    exp_element = '0;
    exp_offset = 0;
    last = (bad_b >= 0) ? bad_b : ((bad_a >= 0) ? bad_a : n - 1);
    cfg.count = 9'(n - 1);
    cfg.base = $random(seed);
    cfg.size = size;
    cfg.mask = mask;
    i_cfg = cfg;
    i_start = 1'b1;
    pulses_before = record_pulses;
    @(negedge clk);
    i_start = 1'b0;
    assert (o_busy && o_rready)
    else
    begin
      event_errors++;
      $display("busy and ready did not rise one cycle after the start pulse");
    end

    for (int i = 0; i <= last && o_rready; i++)
    begin
      do
      begin
        r = $random(seed);
      end
      while (used[r[8:0]]);
      used[r[8:0]] = 1'b1;
      pattern = {23'd0, r[8:0]} + cfg.base;
      expect_line = repeat_pattern(pattern, nb);
      rsp.valid = 1'b1;
      rsp.id = r[8:0];
      rsp.data = expect_line;
      rsp.resp = (i == slverr_at) ? axi_rsp_pkg::RESP_SLVERR : axi_rsp_pkg::RESP_OKAY;
      rsp.poison = (i == poison_at);
      for (int b = 0; b < 64; b++)
      begin
        r = $random(seed);
        if (noise && !mask[b])
          rsp.data[8*b +: 8] = rsp.data[8*b +: 8] ^ r[7:0];
      end
      // two unmasked bytes so that the lowest-offset rule is exercised
      if (i == bad_a || i == bad_b)
      begin
        repeat (2)
        begin
          do
          begin
            r = $random(seed);
          end
          while (!mask[r[5:0]]);
          rsp.data[8*r[5:0] +: 8] = rsp.data[8*r[5:0] +: 8] ^ (r[15:8] | 8'h01);
        end
      end

      for (int b = 0; b < 64; b++)
        mism[b] = mask[b] && (rsp.data[8*b +: 8] != expect_line[8*b +: 8]);
      if (mism != '0 && !exp_found)
      begin
        exp_found = 1'b1;
        exp_id = rsp.id;
        exp_pattern = pattern;
        for (int b = 63; b >= 0; b--)
          if (mism[b])
            exp_offset = b;
        pos = (exp_offset / nb) * nb;
        for (int j = 0; j < nb; j++)
          exp_element[8*j +: 8] = rsp.data[8*(pos + j) +: 8];
      end
      exp_slverr = exp_slverr || (i == slverr_at);
      exp_poison = exp_poison || (i == poison_at);

      i_rsp = rsp;
      sent_total++;
      @(negedge clk);
      i_rsp.valid = 1'b0;
      r = $random(seed);
      repeat (r[1:0])
        @(negedge clk);
    end

    while (o_busy)
      @(negedge clk);
    expect_equal("o_rready", o_rready, 0);
    expect_equal("o_error_found", o_error_found, exp_found);
    expect_equal("o_slverr", o_slverr, exp_slverr);
    expect_equal("o_poison", o_poison, exp_poison);
    if (exp_found)
    begin
      expect_equal("o_error_id", o_error_id, exp_id[7:0]);
      expect_equal("o_expected_pattern", o_expected_pattern, exp_pattern);
      expect_equal("o_byte_offset", o_byte_offset, exp_offset);
      expect_equal("o_received_pattern", o_received_pattern, exp_element);
    end
    assert (record_pulses - pulses_before == (exp_found ? 1 : 0))
    else
    begin
      event_errors++;
      $display("saw %0d record pulses in the run, expected %0d",
               record_pulses - pulses_before, exp_found ? 1 : 0);
    end
  endtask

  // ====================
  // test sequence
  // ====================
  initial
  begin
    seed = 32'haa3e0207;
    reset_n = 1'b0;
    i_start = 1'b0;
    i_cfg = '0;
    i_rsp = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    assert (!o_busy && !o_rready && !o_record_error && !o_error_found && !o_slverr && !o_poison)
    else
    begin
      value_errors++;
      $display("** Error at %0t: status outputs not low after reset", $time);
    end

    play_run(verify_pkg::SIZE_32, '1, 6, -1, -1, 1'b0, -1, -1);
    play_run(verify_pkg::SIZE_16, '1, 5, -1, -1, 1'b0, -1, -1);
    play_run(verify_pkg::SIZE_8, '1, 4, -1, -1, 1'b0, -1, -1);
    part_mask = {$random(seed), $random(seed)};
    play_run(verify_pkg::SIZE_32, part_mask, 6, -1, -1, 1'b1, -1, -1);
    play_run(verify_pkg::SIZE_16, part_mask, 8, 3, -1, 1'b1, -1, -1);
    part_mask = {$random(seed), $random(seed)};
    play_run(verify_pkg::SIZE_32, part_mask, 5, 0, -1, 1'b1, -1, -1);
    play_run(verify_pkg::SIZE_8, part_mask, 6, 1, 2, 1'b0, -1, -1);
    play_run(verify_pkg::SIZE_32, '1, 4, -1, -1, 1'b0, 2, -1);
    play_run(verify_pkg::SIZE_16, '1, 4, -1, -1, 1'b0, -1, 1);
    play_run(verify_pkg::SIZE_8, '1, 3, -1, -1, 1'b0, -1, -1);
    end_simulation();
  end

endmodule

`default_nettype wire

//--- verilog.f
hdl/axi_rsp_pkg.sv
hdl/verify_pkg.sv
hdl/rsp_capture_stage.sv
hdl/pattern_expand.sv
hdl/byte_compare.sv
hdl/error_record.sv
hdl/verify_ctrl.sv
hdl/sc_response_checker.sv
test/tb_sc_response_checker.sv
